// File: source/llc_cfg.svh
/*
  size settings of the llc hit/miss stage
  the tag width must equal address minus index and offset bits
  LLC_SETS must be 2**LLC_INDEX_W and LLC_WAYS a power of two
  LLC_NUM_IDS must be 2**LLC_ID_W
*/
`ifndef LLC_CFG_SVH
`define LLC_CFG_SVH

////////////////////////////////////////////////////////////
// address split
////////////////////////////////////////////////////////////
`define LLC_ADDR_W       32
`define LLC_OFFSET_W     5
`define LLC_INDEX_W      4
`define LLC_SETS         16
`define LLC_TAG_W        (`LLC_ADDR_W - `LLC_INDEX_W - `LLC_OFFSET_W)

// associativity, also the width of the one-hot way vector
`define LLC_WAYS         4

////////////////////////////////////////////////////////////
// ids, miss counters, lock table
////////////////////////////////////////////////////////////
`define LLC_ID_W         4
`define LLC_NUM_IDS      16
`define LLC_CNT_W        3
`define LLC_LOCK_ENTRIES 4

`endif

// File: source/llc_pkg.sv
/*
  types shared by the llc hit/miss stage
  widths come from llc_cfg.svh
  the address union assumes tag, index and offset fill the word exactly
*/
`include "llc_cfg.svh"

package llc_pkg;

  ////////////////////////////////////////////////////////////
  // width types
  ////////////////////////////////////////////////////////////
  // one-hot way vector
  typedef logic [`LLC_WAYS-1:0]     way_t;
  typedef logic [`LLC_INDEX_W-1:0]  index_t;
  typedef logic [`LLC_TAG_W-1:0]    tag_t;
  typedef logic [`LLC_OFFSET_W-1:0] offset_t;
  typedef logic [`LLC_ID_W-1:0]     id_t;
  // per-id outstanding miss count
  typedef logic [`LLC_CNT_W-1:0]    cnt_t;

  ////////////////////////////////////////////////////////////
  // address word
  ////////////////////////////////////////////////////////////
  // field view, msb first
  typedef struct packed {
    tag_t    tag;
    index_t  index;
    offset_t offset;
  } addr_fields_t;

  // same word read raw or split into fields
  typedef union packed {
    logic [`LLC_ADDR_W-1:0] raw;
    addr_fields_t           fields;
  } addr_u;

endpackage

// File: source/llc_tag_store.sv
/*
  tag, valid and dirty store of the llc with round-robin replacement
  after reset it sweeps one set per cycle and ignores requests until init_done_o
  the response is registered and held until the next accepted request
  arrays update at the response edge, a following request sees the update
  evict tag reads zero when no eviction is reported
*/
`timescale 1ns/1ps
`include "llc_cfg.svh"

module llc_tag_store (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           req_valid_i,
  input  llc_pkg::addr_u req_addr_i,
  input  logic           req_write_i,
  output logic           init_done_o,
  output llc_pkg::way_t  res_way_o,
  output logic           res_hit_o,
  output logic           res_evict_o,
  output llc_pkg::tag_t  res_evict_tag_o
);

  localparam int unsigned PTR_W = $clog2(`LLC_WAYS);

  // storage arrays, cleared by the sweep
  llc_pkg::tag_t    tag_mem   [`LLC_SETS][`LLC_WAYS];
  llc_pkg::way_t    valid_mem [`LLC_SETS];
  llc_pkg::way_t    dirty_mem [`LLC_SETS];
  logic [PTR_W-1:0] rr_ptr    [`LLC_SETS];

  // init sweep state
  llc_pkg::index_t  init_cnt_q;
  logic             init_done_q;

  // lookup signals
  llc_pkg::index_t  set;
  llc_pkg::tag_t    req_tag;
  llc_pkg::way_t    hit_vec;
  llc_pkg::way_t    inv_vec;
  llc_pkg::way_t    first_inv;
  llc_pkg::way_t    victim;
  llc_pkg::tag_t    victim_tag;
  logic             hit;
  logic             victim_evict;
  logic             req_take;

  ////////////////////////////////////////////////////////////
  // init sweep
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      init_cnt_q  <= '0;
      init_done_q <= 1'b0;
    end else if (!init_done_q) begin
      init_cnt_q <= init_cnt_q + 1'b1;
      // last set cleared this cycle
      if (init_cnt_q == llc_pkg::index_t'(`LLC_SETS - 1)) begin
        init_done_q <= 1'b1;
      end
    end
  end

  assign init_done_o = init_done_q;
  assign req_take    = req_valid_i & init_done_q;

  ////////////////////////////////////////////////////////////
  // lookup and victim choice
  ////////////////////////////////////////////////////////////
  assign set     = req_addr_i.fields.index;
  assign req_tag = req_addr_i.fields.tag;

  always_comb begin
    hit_vec = '0;
    for (int w = 0; w < `LLC_WAYS; w++) begin
      hit_vec[w] = valid_mem[set][w] && (tag_mem[set][w] == req_tag);
    end
  end

  assign hit       = |hit_vec;
  assign inv_vec   = ~valid_mem[set];
  // lowest set bit of the invalid vector
  assign first_inv = inv_vec & (~inv_vec + 1'b1);
  // all ways valid: fall back to the round-robin pointer
  assign victim    = (|inv_vec) ? first_inv : (llc_pkg::way_t'(1) << rr_ptr[set]);

  // only a valid dirty line needs a write-back
  assign victim_evict = |(victim & valid_mem[set] & dirty_mem[set]);

  always_comb begin
    victim_tag = '0;
    for (int w = 0; w < `LLC_WAYS; w++) begin
      if (victim[w]) begin
        victim_tag = tag_mem[set][w];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // array update and registered response
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!init_done_q) begin
      valid_mem[init_cnt_q] <= '0;
      dirty_mem[init_cnt_q] <= '0;
      rr_ptr[init_cnt_q]    <= '0;
    end else if (req_take) begin
      res_way_o <= hit ? hit_vec : victim;
      res_hit_o <= hit;
      if (hit) begin
        // hit: only a write changes state
        res_evict_o     <= 1'b0;
        res_evict_tag_o <= '0;
        if (req_write_i) begin
          dirty_mem[set] <= dirty_mem[set] | hit_vec;
        end
      end else begin
        res_evict_o     <= victim_evict;
        res_evict_tag_o <= victim_evict ? victim_tag : '0;
        // fill the victim way with the new tag
        for (int w = 0; w < `LLC_WAYS; w++) begin
          if (victim[w]) begin
            tag_mem[set][w] <= req_tag;
          end
        end
        valid_mem[set] <= valid_mem[set] | victim;
        dirty_mem[set] <= req_write_i ? (dirty_mem[set] | victim)
                                      : (dirty_mem[set] & ~victim);
        // pointer moves on every miss
        rr_ptr[set] <= rr_ptr[set] + 1'b1;
      end
    end
  end

endmodule

// File: source/llc_lock_table.sv
/*
  exact table of set/way pairs still in use downstream
  a lock writes the first free entry, an unlock clears the matching one
  locked_o also rises when the table is full, so a lock never gets lost
  the caller locks a pair only after locked_o was low for it
*/
`timescale 1ns/1ps
`include "llc_cfg.svh"

module llc_lock_table (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            lock_i,
  input  llc_pkg::index_t lock_index_i,
  input  llc_pkg::way_t   lock_way_i,
  input  logic            unlock_i,
  input  llc_pkg::index_t unlock_index_i,
  input  llc_pkg::way_t   unlock_way_i,
  output logic            locked_o
);

  // entry payload
  llc_pkg::index_t ent_index [`LLC_LOCK_ENTRIES];
  llc_pkg::way_t   ent_way   [`LLC_LOCK_ENTRIES];
  // entry state
  logic [`LLC_LOCK_ENTRIES-1:0] ent_valid_q;

  logic [`LLC_LOCK_ENTRIES-1:0] match_vec;
  logic [`LLC_LOCK_ENTRIES-1:0] unlock_vec;
  logic [`LLC_LOCK_ENTRIES-1:0] free_sel;

  ////////////////////////////////////////////////////////////
  // compare against all entries
  ////////////////////////////////////////////////////////////
  always_comb begin
    match_vec  = '0;
    unlock_vec = '0;
    for (int e = 0; e < `LLC_LOCK_ENTRIES; e++) begin
      match_vec[e]  = ent_valid_q[e] && (ent_index[e] == lock_index_i) &&
                      (ent_way[e] == lock_way_i);
      unlock_vec[e] = unlock_i && ent_valid_q[e] && (ent_index[e] == unlock_index_i) &&
                      (ent_way[e] == unlock_way_i);
    end
  end

  // lowest clear valid bit, zero when full
  assign free_sel = ~ent_valid_q & (ent_valid_q + 1'b1);

  assign locked_o = (|match_vec) | (&ent_valid_q);

  ////////////////////////////////////////////////////////////
  // entry update
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ent_valid_q <= '0;
    end else begin
      // unlock clears valid entries, lock fills a free one, no overlap
      ent_valid_q <= (ent_valid_q & ~unlock_vec) | (lock_i ? free_sel : '0);
    end
  end

  always_ff @(posedge clk_i) begin
    for (int e = 0; e < `LLC_LOCK_ENTRIES; e++) begin
      if (lock_i && free_sel[e]) begin
        ent_index[e] <= lock_index_i;
        ent_way[e]   <= lock_way_i;
      end
    end
  end

endmodule

// File: source/llc_miss_counters.sv
/*
  outstanding-miss counters, one per transaction id
  counters saturate at both ends
  an increment and a decrement of the same id in one cycle cancel
  outputs describe the id on id_i only
*/
`timescale 1ns/1ps
`include "llc_cfg.svh"

module llc_miss_counters (
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  logic         cnt_up_i,
  input  logic         cnt_down_i,
  input  llc_pkg::id_t cnt_down_id_i,
  input  llc_pkg::id_t id_i,
  output logic         to_miss_o,
  output logic         stall_o
);

  localparam llc_pkg::cnt_t CNT_MAX = '1;

  llc_pkg::cnt_t cnt_q [`LLC_NUM_IDS];

  // decoded strobes per id
  logic [`LLC_NUM_IDS-1:0] up_sel;
  logic [`LLC_NUM_IDS-1:0] down_sel;

  assign up_sel   = cnt_up_i   ? (`LLC_NUM_IDS'(1) << id_i)          : '0;
  assign down_sel = cnt_down_i ? (`LLC_NUM_IDS'(1) << cnt_down_id_i) : '0;

  ////////////////////////////////////////////////////////////
  // counter update
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `LLC_NUM_IDS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `LLC_NUM_IDS; i++) begin
        // up only, stop at max
        if (up_sel[i] && !down_sel[i] && (cnt_q[i] != CNT_MAX)) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        // down only, stop at zero
        end else if (down_sel[i] && !up_sel[i] && (cnt_q[i] != '0)) begin
          cnt_q[i] <= cnt_q[i] - 1'b1;
        end
      end
    end
  end

  // misses of this id still in flight
  assign to_miss_o = (cnt_q[id_i] != '0);
  // no room to count another miss
  assign stall_o   = (cnt_q[id_i] == CNT_MAX);

endmodule

// File: source/llc_hit_miss.sv
/*
  hit/miss stage of the llc, one descriptor held at a time
  no descriptor is taken until the tag store sweep is done
  a descriptor waits while its set/way is locked or its id counter is full
  hits of an id with misses in flight leave on the miss output with refill clear
  once a valid is shown its routing is frozen until the transfer
  unlock and count-down strobes are always taken
*/
`timescale 1ns/1ps

module llc_hit_miss (
  input  logic            clk_i,
  input  logic            arst_n_i,
  // descriptor input
  input  logic            valid_i,
  output logic            ready_o,
  input  llc_pkg::addr_u  addr_i,
  input  llc_pkg::id_t    id_i,
  input  logic            rw_i,
  // hit and miss outputs, shared fields
  output logic            hit_valid_o,
  input  logic            hit_ready_i,
  output logic            miss_valid_o,
  input  logic            miss_ready_i,
  output llc_pkg::addr_u  addr_o,
  output llc_pkg::id_t    id_o,
  output logic            rw_o,
  output llc_pkg::way_t   way_o,
  output logic            refill_o,
  output logic            evict_o,
  output llc_pkg::tag_t   evict_tag_o,
  // unlock strobe
  input  logic            unlock_i,
  input  llc_pkg::index_t unlock_index_i,
  input  llc_pkg::way_t   unlock_way_i,
  // count-down strobe
  input  logic            cnt_down_i,
  input  llc_pkg::id_t    cnt_down_id_i
);

  // control state
  logic           busy_q;
  logic           shown_q;
  logic           to_miss_q;
  // held descriptor
  llc_pkg::addr_u addr_q;
  llc_pkg::id_t   id_q;
  logic           rw_q;

  // tag store response
  logic           init_done;
  llc_pkg::way_t  res_way;
  logic           res_hit;
  logic           res_evict;
  llc_pkg::tag_t  res_evict_tag;

  // lock table and counters
  logic           locked;
  logic           to_miss;
  logic           stall;

  logic           accept;
  logic           go;
  logic           to_miss_eff;
  logic           route_miss;
  logic           xfer_hit;
  logic           xfer_miss;
  logic           xfer;

  ////////////////////////////////////////////////////////////
  // routing control
  ////////////////////////////////////////////////////////////
  // locked and stall can only fall while shown, keep the valid up
  assign go          = busy_q & (shown_q | (~locked & ~stall));
  // a count-down while shown must not move the descriptor
  assign to_miss_eff = shown_q ? to_miss_q : to_miss;
  assign route_miss  = to_miss_eff | ~res_hit;

  assign hit_valid_o  = go & ~route_miss;
  assign miss_valid_o = go &  route_miss;

  assign xfer_hit  = hit_valid_o  & hit_ready_i;
  assign xfer_miss = miss_valid_o & miss_ready_i;
  assign xfer      = xfer_hit | xfer_miss;

  // new descriptor when empty or when the held one leaves
  assign ready_o = init_done & (~busy_q | xfer);
  assign accept  = ready_o & valid_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q    <= 1'b0;
      shown_q   <= 1'b0;
      to_miss_q <= 1'b0;
    end else begin
      if (accept) begin
        busy_q <= 1'b1;
      end else if (xfer) begin
        busy_q <= 1'b0;
      end
      if (xfer) begin
        shown_q <= 1'b0;
      end else if (go) begin
        shown_q   <= 1'b1;
        to_miss_q <= to_miss_eff;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= addr_i;
      id_q   <= id_i;
      rw_q   <= rw_i;
    end
  end

  // shared output fields
  assign addr_o      = addr_q;
  assign id_o        = id_q;
  assign rw_o        = rw_q;
  assign way_o       = res_way;
  assign refill_o    = ~res_hit;
  assign evict_o     = res_evict;
  assign evict_tag_o = res_evict_tag;

  ////////////////////////////////////////////////////////////
  // units
  ////////////////////////////////////////////////////////////
  // lookup starts in the acceptance cycle
  llc_tag_store i_tag_store (
    .clk_i           ( clk_i         ),
    .arst_n_i        ( arst_n_i      ),
    .req_valid_i     ( accept        ),
    .req_addr_i      ( addr_i        ),
    .req_write_i     ( rw_i          ),
    .init_done_o     ( init_done     ),
    .res_way_o       ( res_way       ),
    .res_hit_o       ( res_hit       ),
    .res_evict_o     ( res_evict     ),
    .res_evict_tag_o ( res_evict_tag )
  );

  // every transfer locks its set/way
  llc_lock_table i_lock_table (
    .clk_i          ( clk_i                  ),
    .arst_n_i       ( arst_n_i               ),
    .lock_i         ( xfer                   ),
    .lock_index_i   ( addr_q.fields.index    ),
    .lock_way_i     ( res_way                ),
    .unlock_i       ( unlock_i               ),
    .unlock_index_i ( unlock_index_i         ),
    .unlock_way_i   ( unlock_way_i           ),
    .locked_o       ( locked                 )
  );

  // every miss-output transfer counts, refill or forced
  llc_miss_counters i_miss_counters (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .cnt_up_i      ( xfer_miss     ),
    .cnt_down_i    ( cnt_down_i    ),
    .cnt_down_id_i ( cnt_down_id_i ),
    .id_i          ( id_q          ),
    .to_miss_o     ( to_miss       ),
    .stall_o       ( stall         )
  );

endmodule

// File: verif/llc_hit_miss_asserts.sv
/*
  output protocol properties of the llc hit/miss stage
  bound into every llc_hit_miss instance, inactive during reset
*/
`timescale 1ns/1ps
`include "llc_cfg.svh"

module llc_hit_miss_asserts (
  input logic          clk_i,
  input logic          arst_n_i,
  input logic          hit_valid_o,
  input logic          hit_ready_i,
  input logic          miss_valid_o,
  input logic          miss_ready_i,
  input llc_pkg::way_t way_o
);

  // failed properties, read by the testbench at the end
  int fail_cnt = 0;

  // only one output port at a time
  one_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(hit_valid_o && miss_valid_o)) else begin
    fail_cnt++;
    $error("both valids high");
  end

  way_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (hit_valid_o || miss_valid_o) |-> $onehot(way_o)) else begin
    fail_cnt++;
    $error("way_o not one-hot");
  end

  // valid holds until its ready
  hit_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (hit_valid_o && !hit_ready_i) |=> hit_valid_o) else begin
    fail_cnt++;
    $error("hit valid dropped");
  end

  miss_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (miss_valid_o && !miss_ready_i) |=> miss_valid_o) else begin
    fail_cnt++;
    $error("miss valid dropped");
  end

endmodule

bind llc_hit_miss llc_hit_miss_asserts u_asserts (
  .clk_i        ( clk_i        ),
  .arst_n_i     ( arst_n_i     ),
  .hit_valid_o  ( hit_valid_o  ),
  .hit_ready_i  ( hit_ready_i  ),
  .miss_valid_o ( miss_valid_o ),
  .miss_ready_i ( miss_ready_i ),
  .way_o        ( way_o        )
);

// File: verif/llc_hit_miss_tb.sv
/*
  testbench of the llc hit/miss stage
  descriptors are sent one at a time, each waits for its transfer
  inputs change on the falling edge, outputs are sampled mid low phase
  random traffic restricts tags, sets and ids so that hits and forced misses occur
*/
`timescale 1ns/1ps
`include "llc_cfg.svh"

module llc_hit_miss_tb;

  localparam int NUM_DESC = 220;

  typedef struct packed {
    logic [`LLC_ADDR_W-1:0] addr;
    llc_pkg::id_t           id;
    logic                   rw;
    logic                   miss;
    llc_pkg::way_t          way;
    logic                   refill;
    logic                   evict;
    llc_pkg::tag_t          etag;
  } exp_t;

  logic clk_i, arst_n_i, valid_i, ready_o, rw_i, hit_valid_o, hit_ready_i;
  logic miss_valid_o, miss_ready_i, rw_o, refill_o, evict_o, unlock_i, cnt_down_i;
  llc_pkg::addr_u  addr_i, addr_o;
  llc_pkg::id_t    id_i, id_o, cnt_down_id_i;
  llc_pkg::way_t   way_o, unlock_way_i;
  llc_pkg::tag_t   evict_tag_o;
  llc_pkg::index_t unlock_index_i;

  // reference model state
  llc_pkg::tag_t m_tag [`LLC_SETS][`LLC_WAYS];
  llc_pkg::way_t m_valid [`LLC_SETS];
  llc_pkg::way_t m_dirty [`LLC_SETS];
  int            m_rr [`LLC_SETS];
  int            m_cnt [`LLC_NUM_IDS];
  logic [7:0]    lock_q [$];
  llc_pkg::id_t  pending_q [$];
  exp_t          exp_q [$];
  exp_t          last_exp;
  int            xfer_cnt, err_cnt, test_err0;
  logic [31:0]   stim_lfsr, ready_lfsr;
  logic          rnd_ready;

  llc_hit_miss dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // random source and reference model
  ////////////////////////////////////////////////////////////
  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_step(stim_lfsr);
      r = {r[30:0], stim_lfsr[0]};
    end
    return r;
  endfunction

  // looks up and updates the model cache, routing from the model counters
  function automatic exp_t predict(input llc_pkg::addr_u a, input llc_pkg::id_t id,
                                   input logic rw);
    exp_t e;
    int   s;
    int   hw;
    int   vw;
    s  = a.fields.index;
    hw = -1;
    vw = -1;
    e  = '0;
    e.addr = a.raw;
    e.id   = id;
    e.rw   = rw;
    for (int w = 0; w < `LLC_WAYS; w++) begin
      if (m_valid[s][w] && m_tag[s][w] == a.fields.tag) hw = w;
    end
    if (hw >= 0) begin
      e.way = llc_pkg::way_t'(1) << hw;
      if (rw) m_dirty[s][hw] = 1'b1;
    end else begin
      for (int w = `LLC_WAYS - 1; w >= 0; w--) begin
        if (!m_valid[s][w]) vw = w;
      end
      // every way valid, take the round-robin way
      if (vw < 0) vw = m_rr[s];
      e.way    = llc_pkg::way_t'(1) << vw;
      e.refill = 1'b1;
      e.evict  = m_valid[s][vw] && m_dirty[s][vw];
      e.etag   = e.evict ? m_tag[s][vw] : '0;
      m_tag[s][vw]   = a.fields.tag;
      m_valid[s][vw] = 1'b1;
      m_dirty[s][vw] = rw;
      m_rr[s]        = (m_rr[s] + 1) % `LLC_WAYS;
    end
    e.miss = e.refill || (m_cnt[id] != 0);
    return e;
  endfunction

  function automatic logic line_locked(input llc_pkg::index_t idx, input llc_pkg::way_t w);
    foreach (lock_q[i]) begin
      if (lock_q[i] == {idx, w}) return 1'b1;
    end
    return lock_q.size() >= `LLC_LOCK_ENTRIES;
  endfunction

  ////////////////////////////////////////////////////////////
  // compare process
  ////////////////////////////////////////////////////////////
  task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else begin
      $display("FAILED %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  always begin : compare_proc
    exp_t e;
    @(negedge clk_i);
    #10;
    if ((hit_valid_o && hit_ready_i) || (miss_valid_o && miss_ready_i)) begin
      if (exp_q.size() == 0) begin
        $display("transfer seen with no descriptor outstanding");
        err_cnt++;
      end else begin
        e = exp_q.pop_front();
        // a line still held downstream must not leave again
        assert (!line_locked(e.addr[`LLC_OFFSET_W +: `LLC_INDEX_W], e.way)) else begin
          $display("a descriptor left while its line was still locked");
          err_cnt++;
        end
        check_hex("miss_valid_o", miss_valid_o, e.miss);
        check_hex("addr_o", addr_o.raw, e.addr);
        check_hex("id_o", id_o, e.id);
        check_hex("rw_o", rw_o, e.rw);
        check_hex("way_o", way_o, e.way);
        check_hex("refill_o", refill_o, e.refill);
        check_hex("evict_o", evict_o, e.evict);
        check_hex("evict_tag_o", evict_tag_o, e.etag);
        // transfer locks the line and counts a miss
        lock_q.push_back({e.addr[`LLC_OFFSET_W +: `LLC_INDEX_W], e.way});
        if (e.miss) begin
          if (m_cnt[e.id] < 7) m_cnt[e.id]++;
          pending_q.push_back(e.id);
        end
        last_exp = e;
        xfer_cnt++;
      end
    end
  end

  // random back-pressure, ready about three quarters of the time
  always @(negedge clk_i) begin
    if (rnd_ready) begin
      ready_lfsr   = lfsr_step(lfsr_step(ready_lfsr));
      hit_ready_i  = ready_lfsr[0] | ready_lfsr[1];
      ready_lfsr   = lfsr_step(lfsr_step(ready_lfsr));
      miss_ready_i = ready_lfsr[0] | ready_lfsr[1];
    end else begin
      hit_ready_i  = 1'b1;
      miss_ready_i = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////
  // prompt is high when a valid shows one cycle after acceptance
  task automatic send_desc(input logic [31:0] a, input llc_pkg::id_t id, input logic rw,
                           output logic prompt);
    @(negedge clk_i);
    addr_i.raw = a;
    id_i       = id;
    rw_i       = rw;
    valid_i    = 1'b1;
    #5;
    while (!ready_o) begin
      @(negedge clk_i);
      #5;
    end
    exp_q.push_back(predict(addr_i, id, rw));
    @(negedge clk_i);
    valid_i = 1'b0;
    #5;
    prompt = hit_valid_o | miss_valid_o;
  endtask

  task automatic wait_xfer(input int target);
    while (xfer_cnt < target) @(negedge clk_i);
  endtask

  task automatic unlock_line(input llc_pkg::index_t idx, input llc_pkg::way_t w);
    foreach (lock_q[i]) begin
      if (lock_q[i] == {idx, w}) begin
        lock_q.delete(i);
        break;
      end
    end
    @(negedge clk_i);
    unlock_i       = 1'b1;
    unlock_index_i = idx;
    unlock_way_i   = w;
    @(negedge clk_i);
    unlock_i = 1'b0;
  endtask

  task automatic count_down(input llc_pkg::id_t id);
    if (m_cnt[id] > 0) m_cnt[id]--;
    @(negedge clk_i);
    cnt_down_i    = 1'b1;
    cnt_down_id_i = id;
    @(negedge clk_i);
    cnt_down_i = 1'b0;
  endtask

  // full round trip, optional unlock and count-down afterwards
  task automatic run_desc(input logic [31:0] a, input llc_pkg::id_t id, input logic rw,
                          input logic do_unlock, input logic do_cnt, output logic prompt);
    int target;
    target = xfer_cnt + 1;
    send_desc(a, id, rw, prompt);
    wait_xfer(target);
    if (do_unlock) unlock_line(last_exp.addr[`LLC_OFFSET_W +: `LLC_INDEX_W], last_exp.way);
    if (do_cnt && last_exp.miss) count_down(last_exp.id);
  endtask

  function automatic logic [31:0] make_addr(input llc_pkg::tag_t t, input llc_pkg::index_t i);
    return {t, i, `LLC_OFFSET_W'(0)};
  endfunction

  task automatic end_test(input string name);
    $display("test %s done, %0d errors", name, err_cnt - test_err0);
    test_err0 = err_cnt;
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////
  initial begin : main_proc
    logic p;
    int   target;
    {valid_i, rw_i, unlock_i, cnt_down_i, rnd_ready} = '0;
    {hit_ready_i, miss_ready_i} = 2'b11;
    addr_i = '0;
    id_i = '0;
    cnt_down_id_i = '0;
    unlock_index_i = '0;
    unlock_way_i = '0;
    stim_lfsr  = 32'h7a7b;
    ready_lfsr = 32'h7a7b;
    {xfer_cnt, err_cnt, test_err0} = '0;
    for (int s = 0; s < `LLC_SETS; s++) begin
      m_valid[s] = '0;
      m_dirty[s] = '0;
      m_rr[s]    = 0;
    end
    foreach (m_cnt[i]) m_cnt[i] = 0;
    arst_n_i = 1'b0;
    repeat (8) @(negedge clk_i);
    arst_n_i = 1'b1;

    // sweep keeps the input closed
    for (int k = 1; k < `LLC_SETS; k++) begin
      @(negedge clk_i);
      #5;
      assert (!ready_o) else begin
        $display("ready_o was high during the tag store sweep");
        err_cnt++;
      end
    end
    run_desc(make_addr(23'h1, 4'h0), 4'h0, 1'b0, 1'b1, 1'b1, p);
    end_test("init");

    run_desc(make_addr(23'h1, 4'h0), 4'h0, 1'b0, 1'b1, 1'b1, p);
    assert (p) else begin
      $display("hit valid did not rise one cycle after acceptance");
      err_cnt++;
    end
    end_test("hit_after_fill");

    // first fill dirty, second clean, then two replacements
    for (int t = 0; t < 6; t++) begin
      run_desc(make_addr(llc_pkg::tag_t'(23'h100 + t), 4'h5), 4'h4, (t == 0), 1'b1, 1'b1, p);
    end
    end_test("replacement");

    run_desc(make_addr(23'h2a, 4'h9), 4'h1, 1'b1, 1'b0, 1'b1, p);
    target = xfer_cnt + 1;
    send_desc(make_addr(23'h2a, 4'h9), 4'h2, 1'b0, p);
    repeat (4) begin
      @(negedge clk_i);
      #5;
      assert (!p && !hit_valid_o && !miss_valid_o) else begin
        $display("a valid rose while the line was still locked");
        err_cnt++;
      end
    end
    unlock_line(4'h9, last_exp.way);
    wait_xfer(target);
    unlock_line(4'h9, last_exp.way);
    end_test("lock_stall");

    run_desc(make_addr(23'h33, 4'h3), 4'h3, 1'b0, 1'b1, 1'b0, p);
    run_desc(make_addr(23'h33, 4'h3), 4'h3, 1'b0, 1'b1, 1'b0, p);
    count_down(4'h3);
    count_down(4'h3);
    run_desc(make_addr(23'h33, 4'h3), 4'h3, 1'b0, 1'b1, 1'b0, p);
    end_test("forced_miss");

    pending_q.delete();
    rnd_ready = 1'b1;
    for (int n = 0; n < 200; n++) begin
      run_desc(make_addr(llc_pkg::tag_t'(rand_bits(2)), llc_pkg::index_t'(rand_bits(2))),
               llc_pkg::id_t'(rand_bits(2)), 1'(rand_bits(1)), 1'b1, 1'b0, p);
      if (pending_q.size() >= 3 || (pending_q.size() > 0 && rand_bits(1))) begin
        count_down(pending_q.pop_front());
      end
    end
    rnd_ready = 1'b0;
    end_test("random");

    err_cnt += dut0.u_asserts.fail_cnt;
    $display("%0d transfers, %0d errors", xfer_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // about 50 cycles per descriptor
  initial begin
    #(NUM_DESC * 50 * 40);
    $display("watchdog expired before all descriptors finished");
    $display("Test failed");
    $finish;
  end

endmodule

// File: files.f
+incdir+source
source/llc_pkg.sv
source/llc_tag_store.sv
source/llc_lock_table.sv
source/llc_miss_counters.sv
source/llc_hit_miss.sv
verif/llc_hit_miss_asserts.sv
verif/llc_hit_miss_tb.sv

// File: run.sh
#!/bin/sh
# build and run the llc hit/miss testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module llc_hit_miss_tb -f files.f -o llc_sim

./obj_dir/llc_sim | tee sim.log

# pass only when the testbench printed its pass line
grep -q "Test completed successfully" sim.log
echo "simulation passed"
